//--- bench/rice_core_assert.sv
`timescale 1ns/10ps
`include "rice_core_defines.svh"

module rice_core_assert (
  input var logic i_clk,
  input var logic i_rst_n,
  input var logic psel,
  input var logic penable,
  input var logic pready,
  input var logic start,
  input var logic done,
  input var logic flush
);
  localparam int DONE_LIMIT = `RICE_CORE_IMEM_DEPTH + 8;

  int failures;

  // no wait states on any access
  pready_during_access: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) (psel && penable) |-> pready
  ) else begin
    $error("pready low during an APB access");
    failures++;
  end

  // a full program plus drain fits in the limit
  done_after_start: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) start |-> ##[1:DONE_LIMIT] done
  ) else begin
    $error("done did not rise after start");
    failures++;
  end

  flush_single_cycle: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) flush |=> !flush
  ) else begin
    $error("flush held longer than one cycle");
    failures++;
  end
endmodule

bind rice_core rice_core_assert u_assert (
  .i_clk    (i_clk),
  .i_rst_n  (i_rst_n),
  .psel     (psel),
  .penable  (penable),
  .pready   (pready),
  .start    (start),
  .done     (done),
  .flush    (pipeline_if.flush)
);

//--- bench/rice_core_tb.sv
`timescale 1ns/10ps
`include "rice_core_defines.svh"

module rice_core_tb;
  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 16;
  localparam int DEPTH = `RICE_CORE_IMEM_DEPTH;
  localparam int NUM_ROWS = 7;
  localparam int POLL_LIMIT = DEPTH + 20;
  // two cycles per access over imem load, readback, control and spare
  localparam int ACCESSES_PER_ROW = DEPTH + 32 + 32;
  localparam longint WATCHDOG_NS = longint'(CLK_PERIOD) *
    (NUM_ROWS * (DEPTH + 20) + (NUM_ROWS + 1) * ACCESSES_PER_ROW * 2 + RESET_CYCLES + 64);
  localparam logic [31:0] NOP = 32'h0000_0013;
  localparam logic [11:0] HOLES [6] = '{12'h00c, 12'h0fc, 12'h102, 12'h280, 12'h300, 12'hffc};

  logic         i_clk;
  logic         i_rst_n;
  logic         psel;
  logic         penable;
  logic         pwrite;
  logic [11:0]  paddr;
  logic [31:0]  pwdata;
  logic [31:0]  prdata;
  logic         pready;
  logic         pslverr;

  logic [31:0]  prog_tbl [NUM_ROWS][DEPTH];
  int           run_tbl [NUM_ROWS];
  logic [31:0]  status_tbl [NUM_ROWS];
  bit           overwrite_tbl [NUM_ROWS];
  logic [31:0]  model_regs [32];
  logic         last_slverr;
  int           errors;
  int           checks;

  rice_core rice_core_inst (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

// --------------------------------------------------
// instruction encoding and reference model
// --------------------------------------------------
  function automatic logic [31:0] encode_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] encode_rtype(logic [6:0] funct7, logic [4:0] rd,
                                               logic [4:0] rs1, logic [4:0] rs2);
    return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] random_alu_inst(logic [4:0] rd, logic [4:0] rs1,
                                                  logic [4:0] rs2);
    int unsigned kind;
    kind = $urandom % 3;
    case (kind)
      0:        return encode_addi(rd, rs1, 12'($urandom));
      1:        return encode_rtype(7'h00, rd, rs1, rs2);
      default:  return encode_rtype(7'h20, rd, rs1, rs2);
    endcase
  endfunction

  // only addi, add and sub write and never to x0
  function automatic void model_step(logic [31:0] inst);
    logic [31:0] a;
    logic [31:0] b;
    a = model_regs[inst[19:15]];
    b = model_regs[inst[24:20]];
    if (inst[11:7] != 5'd0 && inst[14:12] == 3'b000) begin
      if (inst[6:0] == 7'b0010011) begin
        model_regs[inst[11:7]] = a + {{20{inst[31]}}, inst[31:20]};
      end
      else if (inst[6:0] == 7'b0110011 && inst[31:25] == 7'h00) begin
        model_regs[inst[11:7]] = a + b;
      end
      else if (inst[6:0] == 7'b0110011 && inst[31:25] == 7'h20) begin
        model_regs[inst[11:7]] = a - b;
      end
    end
  endfunction

  function automatic void build_table();
    logic [4:0] prev_rd;
    logic [4:0] next_rd;
    foreach (prog_tbl[r, w]) begin
      prog_tbl[r][w] = NOP;
    end
    foreach (status_tbl[r]) begin
      status_tbl[r] = 32'h0000_0002;
      overwrite_tbl[r] = 1'b0;
    end
    for (int w = 0; w < 20; w++) begin
      prog_tbl[0][w] = random_alu_inst(5'($urandom), 5'($urandom), 5'($urandom));
    end
    run_tbl[0] = 20;
    // each result feeds both operands of the next
    prev_rd = 5'd1 + 5'($urandom % 31);
    prog_tbl[1][0] = encode_addi(prev_rd, 5'd0, 12'($urandom));
    for (int w = 1; w < 16; w++) begin
      next_rd = 5'd1 + 5'($urandom % 31);
      prog_tbl[1][w] = random_alu_inst(next_rd, prev_rd, prev_rd);
      prev_rd = next_rd;
    end
    run_tbl[1] = 16;
    // x0 targets then lui, sw, beq and mul
    prog_tbl[2][0] = encode_addi(5'd0, 5'd1, 12'h7ff);
    prog_tbl[2][1] = encode_rtype(7'h00, 5'd0, 5'd2, 5'd3);
    prog_tbl[2][2] = {20'habcde, 5'd4, 7'b0110111};
    prog_tbl[2][3] = {7'd0, 5'd5, 5'd6, 3'b010, 5'd8, 7'b0100011};
    prog_tbl[2][4] = {7'd0, 5'd2, 5'd1, 3'b000, 5'd16, 7'b1100011};
    prog_tbl[2][5] = encode_rtype(7'h01, 5'd7, 5'd1, 5'd2);
    run_tbl[2] = 6;
    for (int w = 0; w < 30; w++) begin
      prog_tbl[3][w] = random_alu_inst(5'($urandom), 5'($urandom), 5'($urandom));
    end
    run_tbl[3] = 12;
    prog_tbl[4] = prog_tbl[3];
    run_tbl[4] = 12;
    for (int w = 0; w < 10; w++) begin
      prog_tbl[5][w] = random_alu_inst(5'($urandom), 5'($urandom), 5'($urandom));
    end
    run_tbl[5] = 0;
    for (int w = 0; w < 60; w++) begin
      prog_tbl[6][w] = random_alu_inst(5'($urandom), 5'($urandom), 5'($urandom));
    end
    run_tbl[6] = 60;
    overwrite_tbl[6] = 1'b1;
  endfunction

// --------------------------------------------------
// apb access and checks
// --------------------------------------------------
  // entered and left on a falling edge
  task automatic apb_access(input logic write, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge i_clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    rdata = prdata;
    last_slverr = pslverr;
    @(negedge i_clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    apb_access(1'b0, addr, 32'd0, data);
  endtask

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
    end
  endtask

  task automatic check_registers();
    logic [31:0] value;
    for (int i = 0; i < 32; i++) begin
      apb_read(`RICE_CORE_ADDR_REG_BASE + 12'(4 * i), value);
      compare_word($sformatf("x%0d", i), model_regs[i], value);
    end
  endtask

  task automatic wait_done(input int row);
    logic [31:0] status;
    int polls;
    status = '0;
    polls = 0;
    while (!status[1] && polls < POLL_LIMIT) begin
      apb_read(`RICE_CORE_ADDR_STATUS, status);
      polls++;
    end
    checks++;
    if (!status[1]) begin
      errors++;
      $display("ERROR time=%0t: row %0d never reported done", $time, row);
    end
    else begin
      compare_word("STATUS", status_tbl[row], status);
    end
  endtask

  // late words of the running program written while busy
  task automatic overwrite_running();
    logic [31:0] status;
    apb_read(`RICE_CORE_ADDR_STATUS, status);
    checks++;
    if (!status[0]) begin
      errors++;
      $display("ERROR time=%0t: core not busy right after start", $time);
    end
    for (int w = 40; w < 60; w++) begin
      apb_write(`RICE_CORE_ADDR_IMEM_BASE + 12'(4 * w),
                encode_addi(5'(w % 31 + 1), 5'd0, 12'h5a5));
    end
  endtask

  task report_and_finish();
    errors += rice_core_inst.u_assert.failures;
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end
    else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

// --------------------------------------------------
// main sequence and watchdog
// --------------------------------------------------
  initial begin
    logic [31:0] status;
    i_clk = 1'b0;
    i_rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    last_slverr = 1'b0;
    errors = 0;
    checks = 0;
    void'($urandom(18901));
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    build_table();
    repeat (RESET_CYCLES) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);

    apb_read(`RICE_CORE_ADDR_STATUS, status);
    compare_word("STATUS", 32'd0, status);
    compare_word("pslverr", 32'd0, 32'(last_slverr));
    check_registers();

    for (int row = 0; row < NUM_ROWS; row++) begin
      for (int w = 0; w < DEPTH; w++) begin
        apb_write(`RICE_CORE_ADDR_IMEM_BASE + 12'(4 * w), prog_tbl[row][w]);
      end
      apb_write(`RICE_CORE_ADDR_RUN_COUNT, 32'(run_tbl[row]));
      apb_read(`RICE_CORE_ADDR_RUN_COUNT, status);
      compare_word("RUN_COUNT", 32'(run_tbl[row]), status);
      apb_write(`RICE_CORE_ADDR_CTRL, 32'h1);
      if (overwrite_tbl[row]) begin
        overwrite_running();
      end
      wait_done(row);
      for (int n = 0; n < run_tbl[row]; n++) begin
        model_step(prog_tbl[row][n]);
      end
      check_registers();
    end

    // reads then one write into holes of the map
    foreach (HOLES[i]) begin
      apb_read(HOLES[i], status);
      compare_word("pslverr", 32'd1, 32'(last_slverr));
    end
    apb_write(12'h300, 32'hdead_beef);
    compare_word("pslverr", 32'd1, 32'(last_slverr));
    check_registers();
    report_and_finish();
  end

  initial begin
    #(WATCHDOG_NS);
    errors++;
    $display("ERROR time=%0t: watchdog expired before the tests finished", $time);
    report_and_finish();
  end
endmodule

//--- design/rice_core.sv
`timescale 1ns/10ps
`include "rice_core_defines.svh"

module rice_core (
  input var logic         i_clk,
  input var logic         i_rst_n,
  input var logic         psel,
  input var logic         penable,
  input var logic         pwrite,
  input var logic [11:0]  paddr,
  input var logic [31:0]  pwdata,
  output logic [31:0]     prdata,
  output logic            pready,
  output logic            pslverr
);
  logic                                     start;
  logic [31:0]                              run_count;
  logic                                     imem_we;
  logic [$clog2(`RICE_CORE_IMEM_DEPTH)-1:0] imem_addr;
  logic [31:0]                              imem_data;
  logic                                     busy;
  logic                                     done;
  logic                                     fetch_en;
  logic                                     core_en;

  rice_core_pipeline_if pipeline_if ();

// --------------------------------------------------
// host side
// --------------------------------------------------
  rice_core_apb_regs u_apb_regs (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .busy         (busy),
    .done         (done),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .start        (start),
    .run_count    (run_count),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .pipeline_if  (pipeline_if)
  );

  rice_core_run_ctrl u_run_ctrl (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .start        (start),
    .run_count    (run_count),
    .fetch_en     (fetch_en),
    .core_en      (core_en),
    .busy         (busy),
    .done         (done),
    .pipeline_if  (pipeline_if)
  );

// --------------------------------------------------
// pipeline
// --------------------------------------------------
  rice_core_if_stage u_if_stage (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .fetch_en     (fetch_en),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .pipeline_if  (pipeline_if)
  );

  rice_core_id_stage #(
    .XLEN (`RICE_CORE_XLEN)
  ) u_id_stage (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_enable     (core_en),
    .pipeline_if  (pipeline_if)
  );

  rice_core_ex_stage #(
    .XLEN (`RICE_CORE_XLEN)
  ) u_ex_stage (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_enable     (core_en),
    .pipeline_if  (pipeline_if)
  );
endmodule

//--- design/rice_core_apb_regs.sv
`timescale 1ns/10ps
`include "rice_core_defines.svh"

module rice_core_apb_regs (
  input var logic                                     i_clk,
  input var logic                                     i_rst_n,
  input var logic                                     psel,
  input var logic                                     penable,
  input var logic                                     pwrite,
  input var logic [11:0]                              paddr,
  input var logic [31:0]                              pwdata,
  input var logic                                     busy,
  input var logic                                     done,
  output logic [31:0]                                 prdata,
  output logic                                        pready,
  output logic                                        pslverr,
  output logic                                        start,
  output logic [31:0]                                 run_count,
  output logic                                        imem_we,
  output logic [$clog2(`RICE_CORE_IMEM_DEPTH)-1:0]    imem_addr,
  output logic [31:0]                                 imem_data,
  rice_core_pipeline_if.host                          pipeline_if
);
  localparam int          IMEM_AW   = $clog2(`RICE_CORE_IMEM_DEPTH);
  localparam logic [11:0] IMEM_SPAN = 12'(4 * `RICE_CORE_IMEM_DEPTH);
  localparam logic [11:0] REG_SPAN  = 12'(4 * 32);

  logic         access;
  logic         write;
  logic         aligned;
  logic [11:0]  imem_offset;
  logic [11:0]  reg_offset;
  logic         hit_ctrl;
  logic         hit_count;
  logic         hit_status;
  logic         hit_imem;
  logic         hit_reg;

  assign access       = psel && penable;
  assign write        = access && pwrite;
  assign aligned      = paddr[1:0] == 2'b00;
  assign imem_offset  = paddr - `RICE_CORE_ADDR_IMEM_BASE;
  assign reg_offset   = paddr - `RICE_CORE_ADDR_REG_BASE;

// --------------------------------------------------
// address decode
// --------------------------------------------------
  assign hit_ctrl   = paddr == `RICE_CORE_ADDR_CTRL;
  assign hit_count  = paddr == `RICE_CORE_ADDR_RUN_COUNT;
  assign hit_status = paddr == `RICE_CORE_ADDR_STATUS;
  assign hit_imem   = aligned && (paddr >= `RICE_CORE_ADDR_IMEM_BASE) && (imem_offset < IMEM_SPAN);
  assign hit_reg    = aligned && (paddr >= `RICE_CORE_ADDR_REG_BASE) && (reg_offset < REG_SPAN);

  assign pready   = 1'b1;
  assign pslverr  = access && !(hit_ctrl || hit_count || hit_status || hit_imem || hit_reg);

  // program cannot change under a running core
  assign start      = write && hit_ctrl && pwdata[0] && !busy;
  assign imem_we    = write && hit_imem && !busy;
  assign imem_addr  = imem_offset[IMEM_AW+1:2];
  assign imem_data  = pwdata;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      run_count <= '0;
    end
    else if (write && hit_count) begin
      run_count <= pwdata;
    end
  end

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (hit_status) begin
        prdata = {30'd0, done, busy};
      end
      else if (hit_count) begin
        prdata = run_count;
      end
      else if (hit_reg) begin
        prdata = pipeline_if.register_file[reg_offset[6:2]];
      end
    end
  end
endmodule

//--- design/rice_core_defines.svh
`ifndef RICE_CORE_DEFINES_SVH
`define RICE_CORE_DEFINES_SVH

// data path sizes
`define RICE_CORE_XLEN        32
`define RICE_CORE_IMEM_DEPTH  64

// apb byte offsets
`define RICE_CORE_ADDR_CTRL       12'h000
`define RICE_CORE_ADDR_RUN_COUNT  12'h004
`define RICE_CORE_ADDR_STATUS     12'h008
`define RICE_CORE_ADDR_IMEM_BASE  12'h100
`define RICE_CORE_ADDR_REG_BASE   12'h200

`endif

//--- design/rice_core_ex_stage.sv
`timescale 1ns/10ps
`include "rice_core_defines.svh"

module rice_core_ex_stage
  import rice_core_pkg::*;
#(
  parameter int XLEN = `RICE_CORE_XLEN
)(
  input var logic                 i_clk,
  input var logic                 i_rst_n,
  input var logic                 i_enable,
  rice_core_pipeline_if.ex_stage  pipeline_if
);
  rice_core_id_result     id_result;
  rice_core_ex_result     ex_result;
  rice_core_value [31:0]  register_file;
  logic [XLEN-1:0]        operand_1;
  logic [XLEN-1:0]        operand_2;
  logic [XLEN-1:0]        alu_result;

  function automatic logic [XLEN-1:0] select_source(
    rice_core_alu_source  source,
    logic [XLEN-1:0]      rs_value,
    logic [XLEN-1:0]      imm_value
  );
    case (source)
      RICE_CORE_ALU_SOURCE_RS:  return rs_value;
      RICE_CORE_ALU_SOURCE_IMM: return imm_value;
      default:                  return '0;
    endcase
  endfunction

  assign id_result = pipeline_if.id_result;

  always_comb begin
    operand_1 = select_source(id_result.alu_operation.source_1, id_result.rs1_value,
                              id_result.imm_value);
    operand_2 = select_source(id_result.alu_operation.source_2, id_result.rs2_value,
                              id_result.imm_value);
    case (id_result.alu_operation.command)
      RICE_CORE_ALU_ADD:  alu_result = operand_1 + operand_2;
      RICE_CORE_ALU_SUB:  alu_result = operand_1 - operand_2;
      default:            alu_result = '0;
    endcase
  end

  // no-ops retire with rd cleared so they never write or forward
  always_comb begin
    ex_result.valid = i_enable && id_result.valid;
    ex_result.rd    = (id_result.alu_operation.command != RICE_CORE_ALU_NONE) ? id_result.rd : '0;
    ex_result.value = alu_result;
  end

  assign pipeline_if.ex_result      = ex_result;
  assign pipeline_if.register_file  = register_file;

  // x0 is never written
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      register_file <= '0;
    end
    else if (ex_result.valid && (ex_result.rd != '0)) begin
      register_file[ex_result.rd] <= ex_result.value;
    end
  end
endmodule

//--- design/rice_core_id_stage.sv
`timescale 1ns/10ps
`include "rice_core_defines.svh"

module rice_core_id_stage
  import rice_core_pkg::*;
#(
  parameter int XLEN = `RICE_CORE_XLEN
)(
  input var logic                 i_clk,
  input var logic                 i_rst_n,
  input var logic                 i_enable,
  rice_core_pipeline_if.id_stage  pipeline_if
);
  rice_core_if_result if_result;
  rice_core_id_result id_result;
  rice_core_rs        rs1;
  rice_core_rs        rs2;

  function automatic rice_core_rs decode_rs1(rice_core_inst inst);
    case (get_inst_type(inst.r_type.opcode))
      RICE_CORE_INST_TYPE_U,
      RICE_CORE_INST_TYPE_J:  return '0;
      default:                return inst.r_type.rs1;
    endcase
  endfunction

  function automatic rice_core_rs decode_rs2(rice_core_inst inst);
    case (get_inst_type(inst.r_type.opcode))
      RICE_CORE_INST_TYPE_I,
      RICE_CORE_INST_TYPE_U,
      RICE_CORE_INST_TYPE_J:  return '0;
      default:                return inst.r_type.rs2;
    endcase
  endfunction

  function automatic rice_core_rd decode_rd(rice_core_inst inst);
    case (get_inst_type(inst.r_type.opcode))
      RICE_CORE_INST_TYPE_S,
      RICE_CORE_INST_TYPE_B:  return '0;
      default:                return inst.r_type.rd;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] decode_imm(rice_core_inst inst);
    case (get_inst_type(inst.r_type.opcode))
      RICE_CORE_INST_TYPE_I:
        return {{(XLEN-11){inst.i_type.imm_11}}, inst.i_type.imm_10_0};
      RICE_CORE_INST_TYPE_S:
        return {{(XLEN-11){inst.s_type.imm_11}}, inst.s_type.imm_10_5, inst.s_type.imm_4_0};
      RICE_CORE_INST_TYPE_B:
        return {{(XLEN-12){inst.b_type.imm_12}}, inst.b_type.imm_11, inst.b_type.imm_10_5,
                inst.b_type.imm_4_1, 1'b0};
      RICE_CORE_INST_TYPE_U:
        return {{(XLEN-31){inst.u_type.imm_31}}, inst.u_type.imm_30_12, 12'd0};
      RICE_CORE_INST_TYPE_J:
        return {{(XLEN-20){inst.j_type.imm_20}}, inst.j_type.imm_19_12, inst.j_type.imm_11,
                inst.j_type.imm_10_1, 1'b0};
      default:
        return '0;
    endcase
  endfunction

  function automatic rice_core_alu_operation decode_alu_operation(rice_core_inst inst);
    rice_core_alu_operation operation;
    operation = '{RICE_CORE_ALU_NONE, RICE_CORE_ALU_SOURCE_IMM_0, RICE_CORE_ALU_SOURCE_IMM_0};
    case ({inst.r_type.opcode, inst.r_type.funct3, inst.r_type.funct7}) inside
      {RICE_CORE_OPCODE_OP_IMM, 3'b000, 7'b???????}:  // addi
        operation = '{RICE_CORE_ALU_ADD, RICE_CORE_ALU_SOURCE_RS, RICE_CORE_ALU_SOURCE_IMM};
      {RICE_CORE_OPCODE_OP, 3'b000, 7'b0000000}:      // add
        operation = '{RICE_CORE_ALU_ADD, RICE_CORE_ALU_SOURCE_RS, RICE_CORE_ALU_SOURCE_RS};
      {RICE_CORE_OPCODE_OP, 3'b000, 7'b0100000}:      // sub
        operation = '{RICE_CORE_ALU_SUB, RICE_CORE_ALU_SOURCE_RS, RICE_CORE_ALU_SOURCE_RS};
      default: ;
    endcase
    return operation;
  endfunction

  // bypass the result being written back this cycle
  function automatic rice_core_value read_operand(
    rice_core_rs            rs,
    rice_core_ex_result     ex_result,
    rice_core_value [31:0]  register_file
  );
    if (ex_result.valid && (ex_result.rd != '0) && (ex_result.rd == rs)) begin
      return ex_result.value;
    end
    return register_file[rs];
  endfunction

// --------------------------------------------------
// decode register
// --------------------------------------------------
  assign if_result              = pipeline_if.if_result;
  assign pipeline_if.id_result  = id_result;
  assign rs1                    = decode_rs1(if_result.inst);
  assign rs2                    = decode_rs2(if_result.inst);

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      id_result <= '0;
    end
    else if (pipeline_if.flush || !i_enable) begin
      id_result <= '0;
    end
    else begin
      id_result.valid <= if_result.valid;
      if (if_result.valid) begin
        id_result.pc            <= if_result.pc;
        id_result.rs1           <= rs1;
        id_result.rs2           <= rs2;
        id_result.rd            <= decode_rd(if_result.inst);
        id_result.rs1_value     <= read_operand(rs1, pipeline_if.ex_result,
                                                pipeline_if.register_file);
        id_result.rs2_value     <= read_operand(rs2, pipeline_if.ex_result,
                                                pipeline_if.register_file);
        id_result.imm_value     <= decode_imm(if_result.inst);
        id_result.alu_operation <= decode_alu_operation(if_result.inst);
      end
    end
  end
endmodule

//--- design/rice_core_if_stage.sv
`timescale 1ns/10ps
`include "rice_core_defines.svh"

module rice_core_if_stage
  import rice_core_pkg::*;
(
  input var logic                                   i_clk,
  input var logic                                   i_rst_n,
  input var logic                                   fetch_en,
  input var logic                                   imem_we,
  input var logic [$clog2(`RICE_CORE_IMEM_DEPTH)-1:0] imem_addr,
  input var logic [31:0]                            imem_data,
  rice_core_pipeline_if.if_stage                    pipeline_if
);
  localparam int IMEM_AW = $clog2(`RICE_CORE_IMEM_DEPTH);

  logic [31:0]        imem [`RICE_CORE_IMEM_DEPTH];
  rice_core_value     pc;
  rice_core_if_result if_result;

  assign pipeline_if.if_result = if_result;

  always_ff @(posedge i_clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_data;
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc        <= '0;
      if_result <= '0;
    end
    else if (pipeline_if.flush) begin
      pc        <= '0;
      if_result <= '0;
    end
    else begin
      if_result.valid <= fetch_en;
      if (fetch_en) begin
        pc              <= pc + 32'd4;
        if_result.pc    <= pc;
        if_result.inst  <= imem[pc[IMEM_AW+1:2]];
      end
    end
  end
endmodule

//--- design/rice_core_issue_counter.sv
`timescale 1ns/10ps

module rice_core_issue_counter (
  input var logic         i_clk,
  input var logic         i_rst_n,
  input var logic         clear,
  input var logic         count_en,
  input var logic [31:0]  run_count,
  output logic            reached
);
  logic [31:0]  count;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      count <= '0;
    end
    else if (clear) begin
      count <= '0;
    end
    else if (count_en) begin
      count <= count + 32'd1;
    end
  end

  // zero run count drains at once
  assign reached = count >= run_count;
endmodule

//--- design/rice_core_pipeline_if.sv
`timescale 1ns/10ps

interface rice_core_pipeline_if
  import rice_core_pkg::*;
();
  rice_core_if_result     if_result;
  rice_core_id_result     id_result;
  rice_core_ex_result     ex_result;
  rice_core_value [31:0]  register_file;
  logic                   flush;

  modport if_stage (
    input   flush,
    output  if_result
  );

  modport id_stage (
    input   flush,
    input   if_result,
    input   ex_result,
    input   register_file,
    output  id_result
  );

  modport ex_stage (
    input   id_result,
    output  ex_result,
    output  register_file
  );

  // drain detection reads only the valid bits
  modport ctrl (
    input   if_result,
    input   id_result,
    input   ex_result,
    output  flush
  );

  modport host (
    input   register_file
  );
endinterface

//--- design/rice_core_pkg.sv
`include "rice_core_defines.svh"

package rice_core_pkg;
  typedef logic [4:0]                 rice_core_rs;
  typedef logic [4:0]                 rice_core_rd;
  typedef logic [`RICE_CORE_XLEN-1:0] rice_core_value;

  typedef enum logic [6:0] {
    RICE_CORE_OPCODE_LOAD   = 7'b0000011,
    RICE_CORE_OPCODE_OP_IMM = 7'b0010011,
    RICE_CORE_OPCODE_AUIPC  = 7'b0010111,
    RICE_CORE_OPCODE_STORE  = 7'b0100011,
    RICE_CORE_OPCODE_OP     = 7'b0110011,
    RICE_CORE_OPCODE_LUI    = 7'b0110111,
    RICE_CORE_OPCODE_BRANCH = 7'b1100011,
    RICE_CORE_OPCODE_JALR   = 7'b1100111,
    RICE_CORE_OPCODE_JAL    = 7'b1101111
  } rice_core_opcode;

  typedef enum logic [2:0] {
    RICE_CORE_INST_TYPE_R,
    RICE_CORE_INST_TYPE_I,
    RICE_CORE_INST_TYPE_S,
    RICE_CORE_INST_TYPE_B,
    RICE_CORE_INST_TYPE_U,
    RICE_CORE_INST_TYPE_J
  } rice_core_inst_type;

// --------------------------------------------------
// instruction formats
// --------------------------------------------------
  typedef struct packed {
    logic [6:0]       funct7;
    rice_core_rs      rs2;
    rice_core_rs      rs1;
    logic [2:0]       funct3;
    rice_core_rd      rd;
    rice_core_opcode  opcode;
  } rice_core_inst_r_type;

  typedef struct packed {
    logic             imm_11;
    logic [10:0]      imm_10_0;
    rice_core_rs      rs1;
    logic [2:0]       funct3;
    rice_core_rd      rd;
    rice_core_opcode  opcode;
  } rice_core_inst_i_type;

  typedef struct packed {
    logic             imm_11;
    logic [5:0]       imm_10_5;
    rice_core_rs      rs2;
    rice_core_rs      rs1;
    logic [2:0]       funct3;
    logic [4:0]       imm_4_0;
    rice_core_opcode  opcode;
  } rice_core_inst_s_type;

  typedef struct packed {
    logic             imm_12;
    logic [5:0]       imm_10_5;
    rice_core_rs      rs2;
    rice_core_rs      rs1;
    logic [2:0]       funct3;
    logic [3:0]       imm_4_1;
    logic             imm_11;
    rice_core_opcode  opcode;
  } rice_core_inst_b_type;

  typedef struct packed {
    logic             imm_31;
    logic [18:0]      imm_30_12;
    rice_core_rd      rd;
    rice_core_opcode  opcode;
  } rice_core_inst_u_type;

  typedef struct packed {
    logic             imm_20;
    logic [9:0]       imm_10_1;
    logic             imm_11;
    logic [7:0]       imm_19_12;
    rice_core_rd      rd;
    rice_core_opcode  opcode;
  } rice_core_inst_j_type;

  // six views of one word
  typedef union packed {
    rice_core_inst_r_type r_type;
    rice_core_inst_i_type i_type;
    rice_core_inst_s_type s_type;
    rice_core_inst_b_type b_type;
    rice_core_inst_u_type u_type;
    rice_core_inst_j_type j_type;
  } rice_core_inst;

  function automatic rice_core_inst_type get_inst_type(rice_core_opcode opcode);
    case (opcode)
      RICE_CORE_OPCODE_OP_IMM,
      RICE_CORE_OPCODE_JALR,
      RICE_CORE_OPCODE_LOAD:    return RICE_CORE_INST_TYPE_I;
      RICE_CORE_OPCODE_STORE:   return RICE_CORE_INST_TYPE_S;
      RICE_CORE_OPCODE_BRANCH:  return RICE_CORE_INST_TYPE_B;
      RICE_CORE_OPCODE_LUI,
      RICE_CORE_OPCODE_AUIPC:   return RICE_CORE_INST_TYPE_U;
      RICE_CORE_OPCODE_JAL:     return RICE_CORE_INST_TYPE_J;
      default:                  return RICE_CORE_INST_TYPE_R;
    endcase
  endfunction

// --------------------------------------------------
// alu control and stage results
// --------------------------------------------------
  typedef enum logic [1:0] {
    RICE_CORE_ALU_NONE,
    RICE_CORE_ALU_ADD,
    RICE_CORE_ALU_SUB
  } rice_core_alu_command;

  typedef enum logic [1:0] {
    RICE_CORE_ALU_SOURCE_RS,
    RICE_CORE_ALU_SOURCE_IMM,
    RICE_CORE_ALU_SOURCE_IMM_0
  } rice_core_alu_source;

  typedef struct packed {
    rice_core_alu_command command;
    rice_core_alu_source  source_1;
    rice_core_alu_source  source_2;
  } rice_core_alu_operation;

  typedef struct packed {
    logic           valid;
    rice_core_value pc;
    rice_core_inst  inst;
  } rice_core_if_result;

  typedef struct packed {
    logic                   valid;
    rice_core_value         pc;
    rice_core_rs            rs1;
    rice_core_rs            rs2;
    rice_core_rd            rd;
    rice_core_value         rs1_value;
    rice_core_value         rs2_value;
    rice_core_value         imm_value;
    rice_core_alu_operation alu_operation;
  } rice_core_id_result;

  typedef struct packed {
    logic           valid;
    rice_core_rd    rd;
    rice_core_value value;
  } rice_core_ex_result;
endpackage

//--- design/rice_core_run_ctrl.sv
`timescale 1ns/10ps

module rice_core_run_ctrl (
  input var logic         i_clk,
  input var logic         i_rst_n,
  input var logic         start,
  input var logic [31:0]  run_count,
  output logic            fetch_en,
  output logic            core_en,
  output logic            busy,
  output logic            done,
  rice_core_pipeline_if.ctrl  pipeline_if
);
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN,
    DONE
  } state_t;

  state_t state;
  state_t state_next;
  logic   launch;
  logic   clear;
  logic   count_en;
  logic   reached;
  logic   pipe_empty;

  assign launch     = start && ((state == IDLE) || (state == DONE));
  assign clear      = launch;
  assign count_en   = fetch_en;
  assign pipe_empty = !(pipeline_if.if_result.valid || pipeline_if.id_result.valid ||
                        pipeline_if.ex_result.valid);

  // flush lines up with the start write
  assign pipeline_if.flush = launch;

  assign fetch_en = (state == RUN) && !reached;
  assign core_en  = (state == RUN) || (state == DRAIN);
  assign busy     = core_en;
  assign done     = state == DONE;

  rice_core_issue_counter u_issue_counter (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .clear      (clear),
    .count_en   (count_en),
    .run_count  (run_count),
    .reached    (reached)
  );

  always_comb begin
    state_next = state;
    case (state)
      RUN:      if (reached) state_next = DRAIN;
      DRAIN:    if (pipe_empty) state_next = DONE;
      default:  if (launch) state_next = RUN;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= IDLE;
    end
    else begin
      state <= state_next;
    end
  end
endmodule

//--- vlog.f
+incdir+design
design/rice_core_pkg.sv
design/rice_core_pipeline_if.sv
design/rice_core_issue_counter.sv
design/rice_core_run_ctrl.sv
design/rice_core_apb_regs.sv
design/rice_core_if_stage.sv
design/rice_core_id_stage.sv
design/rice_core_ex_stage.sv
design/rice_core.sv
bench/rice_core_assert.sv
bench/rice_core_tb.sv
